/* design/queen_board_pkg.sv */
package queen_board_pkg;

    // largest board the types can describe
    localparam int N_MAX = 16;

    typedef logic [3:0] row_t;
    typedef logic [3:0] col_t;

    // queens attacking one square
    typedef logic [3:0] count_t;

    // bit set where the square in that row is open
    typedef logic [N_MAX-1:0] row_mask_t;

    // bit set where the column holds a fixed queen
    typedef logic [N_MAX-1:0] col_mask_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } square_t;

    // row of the queen in each column, column 0 in the low slice
    typedef row_t [N_MAX-1:0] board_t;

endpackage

/* design/queen_search_pkg.sv */
package queen_search_pkg;

    typedef enum logic [1:0] {
        op_none,
        op_place,
        op_remove
    } map_op_e;

    // one attack map update per cycle
    typedef struct packed {
        map_op_e                  op;
        queen_board_pkg::square_t sq;
    } map_cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_place,
        st_retract,
        st_done
    } search_state_e;

endpackage

/* design/queen_input_capture.sv */
`timescale 1ns/1ps

module queen_input_capture #(
    parameter int N = 12
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  queen_board_pkg::square_t   in_square,
    input  logic [2:0]                 in_num,
    input  logic                       solved,
    output queen_board_pkg::col_mask_t fixed_cols,
    output queen_board_pkg::board_t    fixed_board,
    output queen_search_pkg::map_cmd_t load_cmd,
    output logic                       load_done
);
    import queen_search_pkg::*;

    logic       busy;
    logic [2:0] remain;
    logic       last_beat;

    // in_num only counts on the first beat
    assign last_beat = in_valid && (busy ? (remain == 3'd1) : (in_num == 3'd1));

    assign load_cmd.op = in_valid ? op_place : op_none;
    assign load_cmd.sq = in_square;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            remain     <= '0;
            fixed_cols <= '0;
            load_done  <= 1'b0;
        end else if (solved) begin
            busy       <= 1'b0;
            remain     <= '0;
            fixed_cols <= '0;
            load_done  <= 1'b0;
        end else begin
            load_done <= last_beat;
            if (in_valid) begin
                busy                      <= 1'b1;
                remain                    <= busy ? remain - 3'd1 : in_num - 3'd1;
                fixed_cols[in_square.col] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fixed_board[in_square.col] <= in_square.row;
        end
    end

    a_beat_legal: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (busy || in_num != 3'd0) &&
                     int'(in_square.col) < N && int'(in_square.row) < N);

endmodule

/* design/queen_attack_map.sv */
`timescale 1ns/1ps

module queen_attack_map #(
    parameter int N = 12
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  queen_search_pkg::map_cmd_t cmd,
    input  logic                       map_clear,
    input  queen_board_pkg::col_mask_t fixed_cols,
    input  queen_board_pkg::col_t      probe_col,
    output queen_board_pkg::row_mask_t open_rows,
    output logic                       dead_ahead
);
    import queen_board_pkg::*;
    import queen_search_pkg::*;

    // column-major, bit c*N+r set when square (r, c) is unattacked
    logic [N*N-1:0] zero_flat;
    row_mask_t      col_open [N];

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            count_t cnt;
            logic   hit;

            // shares a row, column or diagonal with the commanded square
            assign hit = (cmd.sq.row == row_t'(r)) ||
                         (cmd.sq.col == col_t'(c)) ||
                         (r - c == int'(cmd.sq.row) - int'(cmd.sq.col)) ||
                         (r + c == int'(cmd.sq.row) + int'(cmd.sq.col));

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    cnt <= '0;
                end else if (map_clear) begin
                    cnt <= '0;
                end else if (hit && cmd.op == op_place) begin
                    cnt <= cnt + count_t'(1);
                end else if (hit && cmd.op == op_remove) begin
                    cnt <= cnt - count_t'(1);
                end
            end

            assign zero_flat[c*N + r] = (cnt == '0);

            // a remove must undo an earlier place
            a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
                (!map_clear && hit && cmd.op == op_remove) |-> cnt != '0);
        end
    end

    always_comb begin
        for (int c = 0; c < N; c++) begin
            col_open[c]        = '0;
            col_open[c][N-1:0] = zero_flat[c*N +: N];
        end
    end

    assign open_rows = col_open[probe_col];

    // any free column from the probe onward with nowhere left to go
    always_comb begin
        dead_ahead = 1'b0;
        for (int c = 0; c < N; c++) begin
            if (!fixed_cols[c] && col_t'(c) >= probe_col && col_open[c] == '0) begin
                dead_ahead = 1'b1;
            end
        end
    end

endmodule

/* design/queen_search_ctrl.sv */
`timescale 1ns/1ps

module queen_search_ctrl #(
    parameter int N = 12
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  queen_board_pkg::col_mask_t fixed_cols,
    input  queen_board_pkg::board_t    fixed_board,
    input  queen_search_pkg::map_cmd_t load_cmd,
    input  logic                       load_done,
    input  queen_board_pkg::row_mask_t open_rows,
    input  logic                       dead_ahead,
    output queen_search_pkg::map_cmd_t map_cmd,
    output logic                       map_clear,
    output queen_board_pkg::col_t      probe_col,
    output logic                       solved,
    output queen_board_pkg::board_t    board
);
    import queen_board_pkg::*;
    import queen_search_pkg::*;

    search_state_e state;
    col_t          ptr;
    row_t          sel_row;
    // lowest row still allowed per column, N means exhausted
    logic [4:0]    floor_q [N];

    col_t first_free;
    col_t last_free;
    col_t next_free;
    col_t prev_free;
    row_t pick_row;
    logic have_pick;
    logic go_back;

    always_comb begin
        first_free = '0;
        last_free  = '0;
        next_free  = ptr;
        prev_free  = ptr;
        for (int c = N - 1; c >= 0; c--) begin
            if (!fixed_cols[c]) begin
                first_free = col_t'(c);
                if (col_t'(c) > ptr) begin
                    next_free = col_t'(c);
                end
            end
        end
        for (int c = 0; c < N; c++) begin
            if (!fixed_cols[c]) begin
                last_free = col_t'(c);
                if (col_t'(c) < ptr) begin
                    prev_free = col_t'(c);
                end
            end
        end
    end

    // lowest open row at or above the floor
    always_comb begin
        pick_row  = '0;
        have_pick = 1'b0;
        for (int r = N - 1; r >= 0; r--) begin
            if (open_rows[r] && 5'(r) >= floor_q[ptr]) begin
                pick_row  = row_t'(r);
                have_pick = 1'b1;
            end
        end
    end

    assign go_back   = !have_pick || dead_ahead;
    assign probe_col = ptr;
    assign solved    = (state == st_done);
    assign map_clear = (state == st_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ptr   <= '0;
            for (int c = 0; c < N; c++) begin
                floor_q[c] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (load_done) begin
                        ptr   <= first_free;
                        state <= st_select;
                        for (int c = 0; c < N; c++) begin
                            floor_q[c] <= '0;
                        end
                    end
                end
                st_select: begin
                    if (go_back) begin
                        floor_q[ptr] <= '0;
                        ptr          <= prev_free;
                        state        <= st_retract;
                    end else begin
                        state <= st_place;
                    end
                end
                st_place: begin
                    if (ptr == last_free) begin
                        state <= st_done;
                    end else begin
                        ptr   <= next_free;
                        state <= st_select;
                    end
                end
                st_retract: begin
                    floor_q[ptr] <= 5'(board[ptr]) + 5'd1;
                    state        <= st_select;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && load_done) begin
            board <= fixed_board;
        end else if (state == st_place) begin
            board[ptr] <= sel_row;
        end
        if (state == st_select) begin
            sel_row <= pick_row;
        end
    end

    // loading forwards capture commands, searching issues its own
    always_comb begin
        map_cmd.op = op_none;
        map_cmd.sq = '0;
        case (state)
            st_idle: begin
                map_cmd = load_cmd;
            end
            st_place: begin
                map_cmd.op     = op_place;
                map_cmd.sq.row = sel_row;
                map_cmd.sq.col = ptr;
            end
            st_retract: begin
                map_cmd.op     = op_remove;
                map_cmd.sq.row = board[ptr];
                map_cmd.sq.col = ptr;
            end
            default: begin
            end
        endcase
    end

    // backing out of the first free column means the puzzle has no solution
    a_no_backtrack_past_start: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_select && go_back) |-> ptr != first_free);

endmodule

/* design/queen_result_shift.sv */
`timescale 1ns/1ps

module queen_result_shift #(
    parameter int N = 12
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    solved,
    input  queen_board_pkg::board_t board,
    output logic                    out_valid,
    output queen_board_pkg::row_t   out
);
    import queen_board_pkg::*;

    board_t     shreg;
    logic [4:0] sent;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
            sent      <= '0;
        end else if (solved) begin
            out_valid <= 1'b1;
            out       <= board[0];
            sent      <= 5'd1;
        end else if (out_valid) begin
            if (sent == 5'(N)) begin
                out_valid <= 1'b0;
                out       <= '0;
            end else begin
                out  <= shreg[0];
                sent <= sent + 5'd1;
            end
        end
    end

    // column 0 leaves straight from board, the rest step down
    always_ff @(posedge clk) begin
        if (solved) begin
            shreg <= {row_t'(0), board[N_MAX-1:1]};
        end else if (out_valid) begin
            shreg <= {row_t'(0), shreg[N_MAX-1:1]};
        end
    end

endmodule

/* design/queen_top.sv */
`timescale 1ns/1ps

module queen_top #(
    parameter int N = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  queen_board_pkg::col_t col,
    input  queen_board_pkg::row_t row,
    input  logic [2:0]            in_num,
    output logic                  out_valid,
    output queen_board_pkg::row_t out
);
    import queen_board_pkg::*;
    import queen_search_pkg::*;

    square_t   in_square;
    col_mask_t fixed_cols;
    board_t    fixed_board;
    board_t    board;
    map_cmd_t  load_cmd;
    map_cmd_t  map_cmd;
    logic      load_done;
    logic      map_clear;
    logic      dead_ahead;
    logic      solved;
    col_t      probe_col;
    row_mask_t open_rows;

    assign in_square.row = row;
    assign in_square.col = col;

    queen_input_capture #(.N(N)) u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_square  (in_square),
        .in_num     (in_num),
        .solved     (solved),
        .fixed_cols (fixed_cols),
        .fixed_board(fixed_board),
        .load_cmd   (load_cmd),
        .load_done  (load_done)
    );

    queen_attack_map #(.N(N)) u_map (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (map_cmd),
        .map_clear (map_clear),
        .fixed_cols(fixed_cols),
        .probe_col (probe_col),
        .open_rows (open_rows),
        .dead_ahead(dead_ahead)
    );

    queen_search_ctrl #(.N(N)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fixed_cols (fixed_cols),
        .fixed_board(fixed_board),
        .load_cmd   (load_cmd),
        .load_done  (load_done),
        .open_rows  (open_rows),
        .dead_ahead (dead_ahead),
        .map_cmd    (map_cmd),
        .map_clear  (map_clear),
        .probe_col  (probe_col),
        .solved     (solved),
        .board      (board)
    );

    queen_result_shift #(.N(N)) u_shift (
        .clk      (clk),
        .rst_n    (rst_n),
        .solved   (solved),
        .board    (board),
        .out_valid(out_valid),
        .out      (out)
    );

endmodule

/* test/tb_queen.sv */
`timescale 1ns/1ps

module tb_queen;
    import queen_board_pkg::*;

    localparam int N           = 12;
    localparam int TIMEOUT     = 20000;
    localparam int NUM_PUZZLES = 10;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    col_t       col;
    row_t       row;
    logic [2:0] in_num;
    logic       out_valid;
    row_t       out;

    logic [31:0]  lcg_state;
    int           err_count;
    int           timeout_count;
    logic         puzzle_sent;
    logic [N-1:0] fix_mask;
    row_t         fix_row [N];
    int           beat_col [N];
    int           beat_count;
    int           ref_row [N];
    row_t         exp_out [N];
    row_t         emitted [N];
    col_t         out_idx;
    logic         prev_valid;
    logic         clash;

    // known 12-queens boards, row per column
    int sol_table [4][N] = '{
        '{0, 2, 4, 7, 9, 11, 5, 10, 1, 6, 8, 3},
        '{1, 3, 5, 7, 9, 11, 0, 2, 4, 6, 8, 10},
        '{11, 9, 7, 4, 2, 0, 6, 1, 10, 5, 3, 8},
        '{10, 8, 6, 4, 2, 0, 11, 9, 7, 5, 3, 1}
    };

    queen_top #(.N(N)) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .col      (col),
        .row      (row),
        .in_num   (in_num),
        .out_valid(out_valid),
        .out      (out)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int rand_below(int bound);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % bound;
    endfunction

    function automatic bit square_free(int r, int c);
        for (int j = 0; j < N; j++) begin
            if (j != c && ref_row[j] >= 0) begin
                if (ref_row[j] == r || ref_row[j] - j == r - c || ref_row[j] + j == r + c) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // fixed queens taken from one full board, so a completion always exists
    task automatic make_puzzle(int k);
        int s;
        int c;
        s          = rand_below(4);
        fix_mask   = '0;
        beat_count = k;
        for (int i = 0; i < k; i++) begin
            c = rand_below(N);
            while (fix_mask[c]) begin
                c = (c + 1) % N;
            end
            fix_mask[c] = 1'b1;
            fix_row[c]  = row_t'(sol_table[s][c]);
            beat_col[i] = c;
        end
    endtask

    // columns ascending, lowest row first
    task automatic solve_reference();
        int c;
        bit back;
        for (int i = 0; i < N; i++) begin
            ref_row[i] = fix_mask[i] ? int'(fix_row[i]) : -1;
        end
        c    = 0;
        back = 1'b0;
        while (c >= 0 && c < N) begin
            if (fix_mask[c]) begin
                c = back ? c - 1 : c + 1;
            end else begin
                ref_row[c] = ref_row[c] + 1;
                while (ref_row[c] < N && !square_free(ref_row[c], c)) begin
                    ref_row[c] = ref_row[c] + 1;
                end
                if (ref_row[c] < N) begin
                    back = 1'b0;
                    c    = c + 1;
                end else begin
                    ref_row[c] = -1;
                    back       = 1'b1;
                    c          = c - 1;
                end
            end
        end
        if (c < 0) begin
            err_count++;
            $display("reference model found no completion for the puzzle");
        end
        for (int i = 0; i < N; i++) begin
            exp_out[i] = row_t'(ref_row[i]);
        end
    endtask

    task automatic send_puzzle();
        for (int i = 0; i < beat_count; i++) begin
            @(posedge clk);
            in_valid    <= 1'b1;
            col         <= col_t'(beat_col[i]);
            row         <= fix_row[beat_col[i]];
            in_num      <= 3'(beat_count);
            puzzle_sent <= 1'b1;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        col      <= '0;
        row      <= '0;
        in_num   <= '0;
    endtask

    // returns after out_valid has dropped again
    task automatic wait_result();
        int waited;
        waited = 0;
        while (!out_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            timeout_count++;
            $display("timeout: no out_valid within %0d cycles at %0t", TIMEOUT, $time);
        end else begin
            waited = 0;
            while (out_valid && waited < N + 4) begin
                @(negedge clk);
                waited++;
            end
            if (out_valid) begin
                timeout_count++;
                $display("timeout: out_valid still high after %0d cycles", N + 4);
            end
        end
    endtask

    // position inside the current output burst
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_idx    <= '0;
            prev_valid <= 1'b0;
        end else begin
            prev_valid <= out_valid;
            if (out_valid) begin
                if (out_idx < col_t'(N)) begin
                    emitted[out_idx] <= out;
                end
                out_idx <= out_idx + col_t'(1);
            end else begin
                out_idx <= '0;
            end
        end
    end

    // current row against every column already sent
    always_comb begin
        clash = 1'b0;
        for (int j = 0; j < N; j++) begin
            if (col_t'(j) < out_idx &&
                (emitted[j] == out ||
                 int'(emitted[j]) - j == int'(out) - int'(out_idx) ||
                 int'(emitted[j]) + j == int'(out) + int'(out_idx))) begin
                clash = 1'b1;
            end
        end
    end

    a_quiet_before_input: assert property (@(posedge clk) disable iff (!rst_n)
        !puzzle_sent |-> !out_valid)
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out_valid expected 0 got %0b",
                     $time, $sampled(out_valid));
        end

    a_out_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out == '0)
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out expected 0 got %0d", $time, $sampled(out));
        end

    a_row_matches_ref: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_idx < col_t'(N)) |-> out == exp_out[out_idx])
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out[col %0d] expected %0d got %0d", $time,
                     $sampled(out_idx), exp_out[$sampled(out_idx)], $sampled(out));
        end

    a_fixed_queen_kept: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_idx < col_t'(N) && fix_mask[out_idx]) |-> out == fix_row[out_idx])
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out[fixed col %0d] expected %0d got %0d", $time,
                     $sampled(out_idx), fix_row[$sampled(out_idx)], $sampled(out));
        end

    a_no_attack: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !clash)
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t clash[col %0d] expected 0 got 1",
                     $time, $sampled(out_idx));
        end

    a_burst_not_long: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_idx < col_t'(N))
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out_valid length expected %0d got %0d",
                     $time, N, $sampled(out_idx) + 1);
        end

    a_burst_exact: assert property (@(posedge clk) disable iff (!rst_n)
        (prev_valid && !out_valid) |-> out_idx == col_t'(N))
        else begin
            err_count++;
            $display("CHECK FAILED t=%0t out_valid length expected %0d got %0d",
                     $time, N, $sampled(out_idx));
        end

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        col           = '0;
        row           = '0;
        in_num        = '0;
        puzzle_sent   = 1'b0;
        err_count     = 0;
        timeout_count = 0;
        lcg_state     = 32'h7b7b27f2;
        fix_mask      = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // idle window with no input
        repeat (6) @(posedge clk);
        for (int p = 0; p < NUM_PUZZLES && timeout_count == 0; p++) begin
            make_puzzle(p == 0 ? 1 : 1 + rand_below(6));
            solve_reference();
            send_puzzle();
            wait_result();
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d check failures, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/queen_board_pkg.sv
design/queen_search_pkg.sv
design/queen_input_capture.sv
design/queen_attack_map.sv
design/queen_search_ctrl.sv
design/queen_result_shift.sv
design/queen_top.sv
test/tb_queen.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_queen
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Regression failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
